/* logic/mipsAlu.sv */
`timescale 1ns/100ps

module mipsAlu (
  input  logic [31:0]    a,
  input  logic [31:0]    b,
  input  mipsPkg::aluOpT op,
  output logic [31:0]    result,
  output logic           zero
);

  logic lessSigned;
  logic lessUnsigned;

  assign lessSigned   = $signed(a) < $signed(b);
  assign lessUnsigned = a < b;

  always_comb begin
    case (op)
      mipsPkg::aluAdd: result = a + b;
      mipsPkg::aluAnd: result = a & b;
      mipsPkg::aluOr:  result = a | b;

      // set-less-than for slti and sltiu
      mipsPkg::aluSlt:  result = {31'b0, lessSigned};
      mipsPkg::aluSltu: result = {31'b0, lessUnsigned};

      // branch compares
      mipsPkg::aluEq:  result = {31'b0, a == b};
      mipsPkg::aluLez: result = {31'b0, a[31] || (a == 32'd0)};
      mipsPkg::aluLtz: result = {31'b0, a[31]};

      mipsPkg::aluPassA: result = a;  // jr / jalr target
      mipsPkg::aluPassB: result = b;
      default:           result = 32'd0;
    endcase
  end

  assign zero = (result == 32'd0);

endmodule

/* logic/mipsControl.sv */
`timescale 1ns/100ps

module mipsControl (
  input  logic           clk,
  input  logic           rstN,
  input  mipsPkg::instrT instr,
  input  logic           aluZero,
  input  logic           pcIsZero,
  input  logic           waitRequest,
  output mipsPkg::ctrlT  ctrl,
  output logic           read,
  output logic           write,
  output logic           active
);

  mipsPkg::stateT  state;
  mipsPkg::stateT  nextState;
  mipsPkg::opcodeT opcode;
  mipsPkg::functT  funct;
  logic pending;    // taken branch waiting for the delay slot fetch
  logic finish;     // current exec state ends the instruction
  logic zeroTakes;  // branch taken on a zero compare result
  logic immLogic;   // andi and ori zero-extend

  assign opcode   = instr.iType.opcode;
  assign funct    = instr.rType.funct;
  assign immLogic = (opcode == mipsPkg::opAndi) || (opcode == mipsPkg::opOri);
  assign active   = (state != mipsPkg::sHalted);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state   <= mipsPkg::sFetch;
      pending <= 1'b0;
    end else begin
      state <= nextState;
      if (ctrl.branchTake) begin
        pending <= 1'b1;
      end else if (ctrl.pcWrite) begin
        pending <= 1'b0;  // delay slot fetched, pc took the target
      end
    end
  end

  always_comb begin
    ctrl               = '0;
    ctrl.aluOp         = mipsPkg::aluAdd;
    ctrl.branchPending = pending;
    read               = 1'b0;
    write              = 1'b0;
    finish             = 1'b0;
    zeroTakes          = 1'b0;
    nextState          = state;
    case (state)
      mipsPkg::sFetch: begin
        read         = 1'b1;
        ctrl.aluSrcB = 2'd1;  // pc + 4
        if (!waitRequest) begin
          ctrl.irWrite = 1'b1;
          ctrl.pcWrite = 1'b1;
          nextState    = mipsPkg::sDecode;
        end
      end
      mipsPkg::sDecode: begin
        // branch target lands in aluOut while operands are read
        ctrl.aluSrcB = 2'd3;
        ctrl.extSign = 1'b1;
        nextState    = mipsPkg::sExec1;
      end
      mipsPkg::sExec1, mipsPkg::sExec2, mipsPkg::sExec3: begin
        finish = 1'b1;
        case (opcode)
          mipsPkg::opSpecial: begin
            case (funct)
              mipsPkg::fnJr, mipsPkg::fnJalr: begin
                if (funct == mipsPkg::fnJalr && state == mipsPkg::sExec1) begin
                  ctrl.aluSrcB  = 2'd1;  // link is pc + 4
                  ctrl.link     = 1'b1;
                  ctrl.regDst   = 1'b1;
                  ctrl.regWrite = 1'b1;
                  finish        = 1'b0;
                end else begin
                  ctrl.aluSrcA    = 1'b1;
                  ctrl.aluOp      = mipsPkg::aluPassA;
                  ctrl.branchTake = 1'b1;
                end
              end
              default: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.regDst  = 1'b1;
                if (funct == mipsPkg::fnAnd) begin
                  ctrl.aluOp = mipsPkg::aluAnd;
                end else if (funct == mipsPkg::fnOr) begin
                  ctrl.aluOp = mipsPkg::aluOr;
                end
                if (state == mipsPkg::sExec1) begin
                  finish = 1'b0;
                end else begin
                  ctrl.regWrite  = 1'b1;
                  ctrl.aluOutSel = 1'b1;
                end
              end
            endcase
          end
          mipsPkg::opAddiu, mipsPkg::opSlti, mipsPkg::opSltiu,
          mipsPkg::opAndi, mipsPkg::opOri: begin
            ctrl.aluSrcA = 1'b1;
            ctrl.aluSrcB = 2'd2;
            ctrl.extSign = !immLogic;
            case (opcode)
              mipsPkg::opSlti:  ctrl.aluOp = mipsPkg::aluSlt;
              mipsPkg::opSltiu: ctrl.aluOp = mipsPkg::aluSltu;
              mipsPkg::opAndi:  ctrl.aluOp = mipsPkg::aluAnd;
              mipsPkg::opOri:   ctrl.aluOp = mipsPkg::aluOr;
              default:          ctrl.aluOp = mipsPkg::aluAdd;
            endcase
            if (state == mipsPkg::sExec1) begin
              finish = 1'b0;
            end else begin
              ctrl.regWrite  = 1'b1;
              ctrl.aluOutSel = 1'b1;
            end
          end
          mipsPkg::opLw, mipsPkg::opSw: begin
            // same address every exec state so aluOut holds through stalls
            ctrl.aluSrcA = 1'b1;
            ctrl.aluSrcB = 2'd2;
            ctrl.extSign = 1'b1;
            if (state == mipsPkg::sExec1) begin
              finish = 1'b0;
            end else if (state == mipsPkg::sExec2) begin
              ctrl.iorD = 1'b1;
              read      = (opcode == mipsPkg::opLw);
              write     = (opcode == mipsPkg::opSw);
              finish    = (opcode == mipsPkg::opSw);
            end else begin
              ctrl.memToReg = 1'b1;
              ctrl.regWrite = 1'b1;
            end
          end
          mipsPkg::opBeq, mipsPkg::opBne, mipsPkg::opBlez,
          mipsPkg::opBgtz, mipsPkg::opRegimm: begin
            ctrl.aluSrcA   = 1'b1;
            ctrl.aluOutSel = 1'b1;  // target computed in decode
            case (opcode)
              mipsPkg::opBeq: ctrl.aluOp = mipsPkg::aluEq;
              mipsPkg::opBne: begin
                ctrl.aluOp = mipsPkg::aluEq;
                zeroTakes  = 1'b1;
              end
              mipsPkg::opBlez: ctrl.aluOp = mipsPkg::aluLez;
              mipsPkg::opBgtz: begin
                ctrl.aluOp = mipsPkg::aluLez;
                zeroTakes  = 1'b1;
              end
              default: begin
                ctrl.aluOp = mipsPkg::aluLtz;
                zeroTakes  = (instr.iType.rt == mipsPkg::riBgez);
              end
            endcase
            ctrl.branchTake = (aluZero == zeroTakes);
          end
          mipsPkg::opJ, mipsPkg::opJal: begin
            ctrl.jumpSel    = 1'b1;
            ctrl.branchTake = 1'b1;
            ctrl.aluSrcB    = 2'd1;
            ctrl.link       = (opcode == mipsPkg::opJal);
            ctrl.regWrite   = (opcode == mipsPkg::opJal);
          end
          default: ;  // unknown opcode retires as a nop
        endcase
        if ((read || write) && waitRequest) begin
          nextState = state;
        end else if (finish && pcIsZero) begin
          nextState = mipsPkg::sHalted;
        end else if (finish) begin
          nextState = mipsPkg::sFetch;
        end else if (state == mipsPkg::sExec1) begin
          nextState = mipsPkg::sExec2;
        end else begin
          nextState = mipsPkg::sExec3;
        end
      end
      mipsPkg::sHalted: nextState = mipsPkg::sHalted;  // parked until reset
      default: nextState = mipsPkg::sFetch;
    endcase
  end

  aStrobeExcl: assert property (@(posedge clk) disable iff (!rstN) !(read && write))
    else $error("read and write high together");

  aStateLegal: assert property (@(posedge clk) disable iff (!rstN)
    state inside {mipsPkg::sFetch, mipsPkg::sDecode, mipsPkg::sExec1,
                  mipsPkg::sExec2, mipsPkg::sExec3, mipsPkg::sHalted})
    else $error("illegal state %0d", state);

  // a store stays in EXEC2 until the memory accepts it
  aWriteExec2: assert property (@(posedge clk) disable iff (!rstN)
    write && waitRequest |=> write && (state == mipsPkg::sExec2))
    else $error("write dropped or left EXEC2 before it was accepted");

endmodule

/* logic/mipsCore.sv */
`timescale 1ns/100ps

module mipsCore #(
  parameter logic [31:0] resetAddr = 32'hbfc0_0000
) (
  input  logic            clk,
  input  logic            rstN,
  output mipsPkg::memReqT memReq,
  output logic [3:0]      byteEnable,
  input  logic [31:0]     readData,
  input  logic            waitRequest,
  output logic            active
);

  mipsPkg::ctrlT  ctrl;
  mipsPkg::instrT instr;
  logic aluZero;
  logic pcIsZero;

  mipsControl control_i (
    .clk         (clk),
    .rstN        (rstN),
    .instr       (instr),
    .aluZero     (aluZero),
    .pcIsZero    (pcIsZero),
    .waitRequest (waitRequest),
    .ctrl        (ctrl),
    .read        (memReq.read),
    .write       (memReq.write),
    .active      (active)
  );

  mipsDatapath #(
    .resetAddr (resetAddr)
  ) datapath_i (
    .clk       (clk),
    .rstN      (rstN),
    .ctrl      (ctrl),
    .readData  (readData),
    .address   (memReq.address),
    .writeData (memReq.writeData),
    .instr     (instr),
    .aluZero   (aluZero),
    .pcIsZero  (pcIsZero)
  );

  assign byteEnable = 4'b1111;  // word accesses only

endmodule

/* logic/mipsDatapath.sv */
`timescale 1ns/100ps

module mipsDatapath #(
  parameter logic [31:0] resetAddr = 32'hbfc0_0000
) (
  input  logic           clk,
  input  logic           rstN,
  input  mipsPkg::ctrlT  ctrl,
  input  logic [31:0]    readData,
  output logic [31:0]    address,
  output logic [31:0]    writeData,
  output mipsPkg::instrT instr,
  output logic           aluZero,
  output logic           pcIsZero
);

  logic [31:0] pc;
  logic [31:0] regA;
  logic [31:0] regB;
  logic [31:0] aluOut;
  logic [31:0] memData;
  logic [31:0] pendTarget;
  logic [31:0] rfDataA;
  logic [31:0] rfDataB;
  logic [31:0] extImm;
  logic [31:0] srcA;
  logic [31:0] srcB;
  logic [31:0] aluResult;
  logic [31:0] aluSel;
  logic [31:0] jumpTarget;
  logic [31:0] wbData;
  logic [4:0]  wbAddr;

  mipsRegFile regFile_i (
    .clk       (clk),
    .rstN      (rstN),
    .readAddrA (instr.rType.rs),
    .readAddrB (instr.rType.rt),
    .readDataA (rfDataA),
    .readDataB (rfDataB),
    .writeEn   (ctrl.regWrite),
    .writeAddr (wbAddr),
    .writeData (wbData)
  );

  mipsAlu alu_i (
    .a      (srcA),
    .b      (srcB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  assign extImm = ctrl.extSign ? {{16{instr.iType.imm[15]}}, instr.iType.imm}
                               : {16'd0, instr.iType.imm};

  // pc already points at the delay slot here
  assign jumpTarget = {pc[31:28], instr.jType.target, 2'b00};

  assign srcA = ctrl.aluSrcA ? regA : pc;

  always_comb begin
    case (ctrl.aluSrcB)
      2'd0:    srcB = regB;
      2'd1:    srcB = 32'd4;
      2'd2:    srcB = extImm;
      default: srcB = {extImm[29:0], 2'b00};  // branch offset
    endcase
  end

  assign aluSel = ctrl.aluOutSel ? aluOut : aluResult;
  assign wbData = ctrl.memToReg ? memData : aluSel;

  always_comb begin
    if (ctrl.regDst) begin
      wbAddr = instr.rType.rd;
    end else if (ctrl.link) begin
      wbAddr = 5'd31;
    end else begin
      wbAddr = instr.iType.rt;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= resetAddr;
    end else if (ctrl.pcWrite) begin
      pc <= ctrl.branchPending ? pendTarget : aluResult;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.irWrite) begin
      instr <= readData;
    end
    if (ctrl.branchTake) begin
      pendTarget <= ctrl.jumpSel ? jumpTarget : aluSel;
    end
    regA    <= rfDataA;
    regB    <= rfDataB;
    aluOut  <= aluResult;
    memData <= readData;  // valid on the cycle after the accepted read
  end

  assign address   = ctrl.iorD ? aluOut : pc;
  assign writeData = regB;
  assign pcIsZero  = (pc == 32'd0);

  aPcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
    else $error("pc %h not word aligned", pc);

endmodule

/* logic/mipsPkg.sv */
package mipsPkg;

  // primary opcodes, bits 31:26
  typedef enum logic [5:0] {
    opSpecial = 6'b000000,  // register type, decoded by funct
    opRegimm  = 6'b000001,  // bgez / bltz, decoded by rt
    opJ       = 6'b000010,
    opJal     = 6'b000011,
    opBeq     = 6'b000100,
    opBne     = 6'b000101,
    opBlez    = 6'b000110,
    opBgtz    = 6'b000111,
    opAddiu   = 6'b001001,
    opSlti    = 6'b001010,
    opSltiu   = 6'b001011,
    opAndi    = 6'b001100,
    opOri     = 6'b001101,
    opLw      = 6'b100011,
    opSw      = 6'b101011
  } opcodeT;

  typedef enum logic [5:0] {
    fnJr   = 6'b001000,
    fnJalr = 6'b001001,
    fnAddu = 6'b100001,
    fnAnd  = 6'b100100,
    fnOr   = 6'b100101
  } functT;

  typedef enum logic [4:0] {
    riBltz = 5'b00000,
    riBgez = 5'b00001
  } regimmT;

  typedef enum logic [2:0] {
    sFetch  = 3'd0,
    sDecode = 3'd1,
    sExec1  = 3'd2,
    sExec2  = 3'd3,
    sExec3  = 3'd4,
    sHalted = 3'd5
  } stateT;

  // compare ops leave their answer in bit 0
  typedef enum logic [3:0] {
    aluAdd   = 4'd0,
    aluAnd   = 4'd1,
    aluOr    = 4'd2,
    aluSlt   = 4'd3,
    aluSltu  = 4'd4,
    aluEq    = 4'd5,
    aluLez   = 4'd6,
    aluLtz   = 4'd7,
    aluPassA = 4'd8,
    aluPassB = 4'd9
  } aluOpT;

  typedef struct packed {
    opcodeT     opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    functT      funct;
  } rFieldsT;

  typedef struct packed {
    opcodeT      opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iFieldsT;

  typedef struct packed {
    opcodeT      opcode;
    logic [25:0] target;
  } jFieldsT;

  // one instruction word, three formats
  typedef union packed {
    rFieldsT rType;
    iFieldsT iType;
    jFieldsT jType;
  } instrT;

  typedef struct packed {
    logic       irWrite;
    logic       pcWrite;
    logic       regWrite;
    logic       memToReg;       // write back memory data
    logic       regDst;         // 1 selects rd, 0 selects rt
    logic       iorD;           // 1 addresses data via aluOut
    logic       aluSrcA;        // 0 pc, 1 regA
    logic [1:0] aluSrcB;        // regB, 4, imm, imm << 2
    aluOpT      aluOp;
    logic       aluOutSel;      // 1 takes the registered ALU result
    logic       extSign;
    logic       link;           // write back to r31 unless regDst
    logic       jumpSel;        // pending target from the 26-bit field
    logic       branchTake;     // load the pending target
    logic       branchPending;  // next fetch takes the pending target
  } ctrlT;

  typedef struct packed {
    logic [31:0] address;
    logic [31:0] writeData;
    logic        read;
    logic        write;
  } memReqT;

endpackage

/* logic/mipsRegFile.sv */
`timescale 1ns/100ps

module mipsRegFile (
  input  logic        clk,
  input  logic        rstN,
  input  logic [4:0]  readAddrA,
  input  logic [4:0]  readAddrB,
  output logic [31:0] readDataA,
  output logic [31:0] readDataB,
  input  logic        writeEn,
  input  logic [4:0]  writeAddr,
  input  logic [31:0] writeData
);

  logic [31:0] regs [32];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (writeEn && writeAddr != 5'd0) begin
      regs[writeAddr] <= writeData;  // r0 never written, stays zero
    end
  end

  // combinational read ports
  assign readDataA = regs[readAddrA];
  assign readDataB = regs[readAddrB];

endmodule

/* mipsMulti.f */
logic/mipsPkg.sv
logic/mipsAlu.sv
logic/mipsRegFile.sv
logic/mipsDatapath.sv
logic/mipsControl.sv
logic/mipsCore.sv
tb/mipsMemModel.sv
tb/mipsCoreTb.sv

/* tb/mipsCoreTb.sv */
`timescale 1ns/100ps

module mipsCoreTb;

  localparam logic [31:0] resetAddr = 32'h0000_0040;
  localparam logic [31:0] resBase   = 32'h0000_0300;
  localparam logic [31:0] cA = 32'h1234_5678;
  localparam logic [31:0] cB = 32'hf0f0_0f0f;
  localparam logic [31:0] cC = 32'hffff_ff9c;  // -100
  localparam logic [31:0] cD = 32'd5;
  localparam logic [31:0] cE = 32'hcafe_f00d;
  localparam int worstStall = 3;

  logic            clk;
  logic            rstN;
  mipsPkg::memReqT memReq;
  logic [3:0]      byteEnable;
  logic [31:0]     readData;
  logic            waitRequest;
  logic            active;

  logic [31:0] expVal [64];
  logic        slotSeen [64];
  int          groupFirst [6];
  int          groupSeen [5];
  int          groupMiss [5];
  string       groupName [5] = '{"alu", "memory", "branch", "jump", "halt"};
  logic [31:0] at;
  int nextSlot = 0;
  int instrCount = 0;
  int seenTotal = 0;
  int mismatches = 0;
  int failCount = 0;
  int cycles = 0;
  int limit = 0;
  int storeSlot = -1;

  mipsCore #(.resetAddr(resetAddr)) dut_i (
    .clk         (clk),
    .rstN        (rstN),
    .memReq      (memReq),
    .byteEnable  (byteEnable),
    .readData    (readData),
    .waitRequest (waitRequest),
    .active      (active)
  );

  mipsMemModel memModel (
    .clk         (clk),
    .rstN        (rstN),
    .memReq      (memReq),
    .readData    (readData),
    .waitRequest (waitRequest)
  );

  function automatic logic [31:0] rEnc(input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [4:0] rd, input logic [5:0] funct);
    return {6'd0, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic logic [31:0] iEnc(input logic [5:0] op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jEnc(input logic [5:0] op, input logic [31:0] target);
    return {op, target[27:2]};
  endfunction

  // branch rules of the ISA, rt selects bgez or bltz in the regimm group
  function automatic logic takenFor(input logic [5:0] op, input logic [4:0] rt,
                                    input logic [31:0] a, input logic [31:0] b);
    case (op)
      mipsPkg::opBeq:  return a == b;
      mipsPkg::opBne:  return a != b;
      mipsPkg::opBgtz: return $signed(a) > 0;
      mipsPkg::opBlez: return $signed(a) <= 0;
      default:         return (rt == mipsPkg::riBgez) ? ($signed(a) >= 0) : ($signed(a) < 0);
    endcase
  endfunction

  function automatic logic isResultAddr(input logic [31:0] a);
    return (a >= resBase) && (a < resBase + 32'(4 * nextSlot));
  endfunction

  function automatic int slotOf(input logic [31:0] a);
    return int'((a - resBase) >> 2);
  endfunction

  function automatic int groupOf(input int slot);
    for (int g = 0; g < 5; g++) begin
      if (slot >= groupFirst[g] && slot < groupFirst[g+1]) begin
        return g;
      end
    end
    return 4;
  endfunction

  task emit(input logic [31:0] word);
    memModel.mem[at >> 2] = word;
    at = at + 4;
    instrCount++;
  endtask

  task storeResult(input logic [4:0] rt, input logic [31:0] expected);
    emit(iEnc(mipsPkg::opSw, 5'd0, rt, 16'(resBase + 4 * nextSlot)));
    expVal[nextSlot] = expected;
    slotSeen[nextSlot] = 1'b0;
    nextSlot++;
  endtask

  // delay slot sets 16, the fall-through path adds 1
  task branchCase(input logic [5:0] op, input logic [4:0] rs, input logic [4:0] rt,
                  input logic [31:0] a, input logic [31:0] b);
    emit(iEnc(op, rs, rt, 16'd2));
    emit(iEnc(mipsPkg::opAddiu, 5'd0, 5'd12, 16'd16));
    emit(iEnc(mipsPkg::opAddiu, 5'd12, 5'd12, 16'd1));
    storeResult(5'd12, takenFor(op, rt, a, b) ? 32'd16 : 32'd17);
  endtask

  task buildProgram();
    logic [31:0] x;
    at = resetAddr;
    memModel.mem[32'h200 >> 2] = cA;
    memModel.mem[32'h204 >> 2] = cB;
    memModel.mem[32'h208 >> 2] = cC;
    memModel.mem[32'h20c >> 2] = cD;
    memModel.mem[32'h210 >> 2] = cE;
    emit(iEnc(mipsPkg::opLw, 5'd0, 5'd1, 16'h0200));
    emit(iEnc(mipsPkg::opLw, 5'd0, 5'd2, 16'h0204));
    emit(iEnc(mipsPkg::opLw, 5'd0, 5'd3, 16'h0208));
    emit(iEnc(mipsPkg::opLw, 5'd0, 5'd4, 16'h020c));

    groupFirst[0] = nextSlot;
    emit(rEnc(5'd1, 5'd2, 5'd5, mipsPkg::fnAddu));
    storeResult(5'd5, cA + cB);
    emit(rEnc(5'd1, 5'd2, 5'd5, mipsPkg::fnAnd));
    storeResult(5'd5, cA & cB);
    emit(rEnc(5'd1, 5'd2, 5'd5, mipsPkg::fnOr));
    storeResult(5'd5, cA | cB);
    emit(iEnc(mipsPkg::opAddiu, 5'd1, 5'd5, 16'hff38));  // -200
    storeResult(5'd5, cA + 32'hffff_ff38);
    emit(iEnc(mipsPkg::opAndi, 5'd2, 5'd5, 16'h8f0f));
    storeResult(5'd5, cB & 32'h0000_8f0f);
    emit(iEnc(mipsPkg::opOri, 5'd1, 5'd5, 16'h8001));
    storeResult(5'd5, cA | 32'h0000_8001);
    emit(iEnc(mipsPkg::opSlti, 5'd3, 5'd5, 16'h0003));  // -100 < 3 only when signed
    storeResult(5'd5, ($signed(cC) < 3) ? 32'd1 : 32'd0);
    emit(iEnc(mipsPkg::opSltiu, 5'd3, 5'd5, 16'hffce));
    storeResult(5'd5, (cC < 32'hffff_ffce) ? 32'd1 : 32'd0);
    emit(iEnc(mipsPkg::opSltiu, 5'd4, 5'd5, 16'hffce));  // 5 below a huge unsigned imm
    storeResult(5'd5, (cD < 32'hffff_ffce) ? 32'd1 : 32'd0);

    groupFirst[1] = nextSlot;
    emit(iEnc(mipsPkg::opLw, 5'd0, 5'd6, 16'h0210));
    storeResult(5'd6, cE);
    emit(iEnc(mipsPkg::opAddiu, 5'd1, 5'd0, 16'd77));  // r0 must ignore this
    storeResult(5'd0, 32'd0);

    groupFirst[2] = nextSlot;
    branchCase(mipsPkg::opBeq, 5'd4, 5'd4, cD, cD);
    branchCase(mipsPkg::opBeq, 5'd4, 5'd3, cD, cC);
    branchCase(mipsPkg::opBne, 5'd4, 5'd3, cD, cC);
    branchCase(mipsPkg::opBne, 5'd1, 5'd1, cA, cA);
    branchCase(mipsPkg::opBgtz, 5'd4, 5'd0, cD, 32'd0);
    branchCase(mipsPkg::opBgtz, 5'd3, 5'd0, cC, 32'd0);
    branchCase(mipsPkg::opBlez, 5'd3, 5'd0, cC, 32'd0);
    branchCase(mipsPkg::opBlez, 5'd4, 5'd0, cD, 32'd0);
    branchCase(mipsPkg::opRegimm, 5'd4, mipsPkg::riBgez, cD, 32'd0);
    branchCase(mipsPkg::opRegimm, 5'd3, mipsPkg::riBgez, cC, 32'd0);
    branchCase(mipsPkg::opRegimm, 5'd3, mipsPkg::riBltz, cC, 32'd0);
    branchCase(mipsPkg::opRegimm, 5'd4, mipsPkg::riBltz, cD, 32'd0);

    groupFirst[3] = nextSlot;
    x = at;
    emit(jEnc(mipsPkg::opJ, x + 12));
    emit(iEnc(mipsPkg::opAddiu, 5'd0, 5'd12, 16'd16));
    emit(iEnc(mipsPkg::opAddiu, 5'd12, 5'd12, 16'd1));  // skipped
    storeResult(5'd12, 32'd16);
    x = at;
    emit(jEnc(mipsPkg::opJal, x + 12));
    emit(iEnc(mipsPkg::opAddiu, 5'd0, 5'd12, 16'd32));
    emit(iEnc(mipsPkg::opAddiu, 5'd12, 5'd12, 16'd1));
    storeResult(5'd12, 32'd32);
    storeResult(5'd31, x + 8);
    x = at;
    emit(iEnc(mipsPkg::opAddiu, 5'd0, 5'd7, 16'(x + 16)));
    emit(rEnc(5'd7, 5'd0, 5'd0, mipsPkg::fnJr));
    emit(iEnc(mipsPkg::opAddiu, 5'd0, 5'd12, 16'd48));
    emit(iEnc(mipsPkg::opAddiu, 5'd12, 5'd12, 16'd1));
    storeResult(5'd12, 32'd48);
    x = at;
    emit(iEnc(mipsPkg::opAddiu, 5'd0, 5'd8, 16'(x + 16)));
    emit(rEnc(5'd8, 5'd0, 5'd9, mipsPkg::fnJalr));  // link into r9
    emit(iEnc(mipsPkg::opAddiu, 5'd0, 5'd12, 16'd64));
    emit(iEnc(mipsPkg::opAddiu, 5'd12, 5'd12, 16'd1));
    storeResult(5'd12, 32'd64);
    storeResult(5'd9, x + 12);

    groupFirst[4] = nextSlot;
    emit(rEnc(5'd0, 5'd0, 5'd0, mipsPkg::fnJr));
    storeResult(5'd4, cD);  // delay slot still runs before the halt
    groupFirst[5] = nextSlot;
  endtask

  task recordStore(input int slot);
    int g;
    g = groupOf(slot);
    if (!slotSeen[slot]) begin
      slotSeen[slot] = 1'b1;
      seenTotal++;
      groupSeen[g]++;
      if (groupSeen[g] == groupFirst[g+1] - groupFirst[g]) begin
        $display("test %s: %0d stores checked, %0d mismatches", groupName[g], groupSeen[g],
                 groupMiss[g]);
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  aStoreValue: assert property (@(posedge clk) disable iff (!rstN)
    (memReq.write && !waitRequest && isResultAddr(memReq.address))
      |-> memReq.writeData == expVal[slotOf(memReq.address)])
    else begin
      mismatches++;
      failCount++;
      groupMiss[groupOf(slotOf($sampled(memReq.address)))]++;
      $display("ERROR %0t memReq.writeData at %h: got %h expected %h", $time,
               $sampled(memReq.address), $sampled(memReq.writeData),
               expVal[slotOf($sampled(memReq.address))]);
    end

  aStoreArea: assert property (@(posedge clk) disable iff (!rstN)
    (memReq.write && !waitRequest) |-> isResultAddr(memReq.address))
    else begin
      failCount++;
      $display("store to %h landed outside the result area", $sampled(memReq.address));
    end

  aStrobes: assert property (@(posedge clk) disable iff (!rstN) !(memReq.read && memReq.write))
    else begin
      failCount++;
      $display("read and write were high in the same cycle at %0t", $time);
    end

  // word accesses only, every lane enabled
  aByteEnable: assert property (@(posedge clk) disable iff (!rstN)
    (memReq.read || memReq.write) |-> byteEnable == 4'b1111)
    else begin
      failCount++;
      $display("ERROR %0t byteEnable: got %b expected %b", $time, $sampled(byteEnable),
               4'b1111);
    end

  aHaltQuiet: assert property (@(posedge clk) disable iff (!rstN)
    !active |-> !(memReq.read || memReq.write))
    else begin
      failCount++;
      $display("memory access seen after the core halted at %0t", $time);
    end

  // note the accepted store now, count it once the edge has settled
  always @(posedge clk) begin
    if (rstN && memReq.write && !waitRequest && isResultAddr(memReq.address)) begin
      storeSlot = slotOf(memReq.address);
    end else begin
      storeSlot = -1;
    end
  end

  always @(negedge clk) begin
    if (storeSlot >= 0) begin
      recordStore(storeSlot);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    rstN = 1'b0;
    memModel.fillPattern();
    buildProgram();
    limit = 40 * instrCount * worstStall;
    repeat (8) @(posedge clk);
    #1 rstN = 1'b1;
    @(posedge clk);
    while (active) @(posedge clk);
    repeat (40) @(posedge clk);  // bus must stay idle after the halt
    if (seenTotal != nextSlot) begin
      failCount++;
      $display("only %0d of %0d result stores were seen", seenTotal, nextSlot);
    end
    $display("checks: %0d passed, %0d failed", seenTotal - mismatches, failCount);
    if (failCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* tb/mipsMemModel.sv */
`timescale 1ns/100ps

module mipsMemModel #(
  parameter int words = 256
) (
  input  logic            clk,
  input  logic            rstN,
  input  mipsPkg::memReqT memReq,
  output logic [31:0]     readData,
  output logic            waitRequest
);

  localparam int addrBits = $clog2(words);

  logic [31:0] mem [words];
  logic [31:0] lcgState;
  int          stallLeft;  // wait cycles still owed to the next access

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // every word gets a value tied to its byte address
  task fillPattern();
    for (int i = 0; i < words; i++) begin
      mem[i] = 32'h5a00_0000 ^ (i * 4);
    end
    waitRequest = 1'b0;
  endtask

  assign readData = mem[memReq.address[addrBits+1:2]];

  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      lcgState = 32'd84771;
      stallLeft = 0;
      waitRequest <= 1'b0;
    end else begin
      if (memReq.read || memReq.write) begin
        if (stallLeft == 0) begin
          if (memReq.write) begin
            mem[memReq.address[addrBits+1:2]] = memReq.writeData;
          end
          lcgState = lcgNext(lcgState);
          stallLeft = int'(lcgState[17:16]);  // 0 to 3 for the next access
        end else begin
          stallLeft--;
        end
      end
      waitRequest <= #1 (stallLeft != 0);
    end
  end

endmodule
